/* soc_fsb.f */
+incdir+include
source/fsb_pkg.sv
source/dev_pkg.sv
source/fsb_dev_if.sv
source/bus_arbiter.sv
source/mem_map.sv
source/mod_ram.sv
source/mod_gpio.sv
source/mod_timer.sv
source/fsb.sv
test/fsb_checker.sv
test/fsb_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the front side bus testbench with Verilator.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f soc_fsb.f --top-module fsb_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vfsb_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TESTBENCH FAILED" "$LOG"; then
	exit 1
fi
exit 0

/* test/fsb_tb.sv */
////////////////////////////////////////
// Front side bus testbench
////////////////////////////////////////
`timescale 1ns/10ps
`include "fsb_macros.svh"

module fsb_tb;
	localparam int TIMEOUT = 200; // Cycles allowed per wait.

	logic               clk = 1'b0;
	logic               rst_n;
	logic               i_req;
	fsb_pkg::addr_t     i_addr;
	logic               i_valid;
	fsb_pkg::data_t     i_rdata;
	logic               i_credit;
	logic               d_req;
	logic               d_we;
	fsb_pkg::addr_t     d_addr;
	fsb_pkg::data_t     d_wdata;
	logic               d_valid;
	fsb_pkg::data_t     d_rdata;
	logic               d_credit;
	dev_pkg::leds_t     leds;
	dev_pkg::switches_t switches;

	fsb_pkg::data_t ram_model [`RAM_WORDS]; // Reference RAM.
	dev_pkg::leds_t leds_model;
	fsb_pkg::data_t exp_i [$]; // Expected responses, oldest first.
	fsb_pkg::data_t exp_d [$];
	bit             chk_d [$]; // Compare this data response or not.
	fsb_pkg::data_t last_d;    // Latest data response.
	int             i_cred, d_cred, i_sent, d_sent, i_back, d_back;
	int             errors, test_errs, tests, tests_failed;

	fsb dut (.*);

	always #20 clk = ~clk;

	function automatic fsb_pkg::addr_t make_addr(input logic [3:0] dev, input logic [25:0] off);
		return {dev, off, 2'b00}; // Word offset to byte address.
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TESTBENCH FAILED");
		$finish;
	endtask

	// Falling edge: collect responses, then release the request lines.
	task automatic next_cycle();
		fsb_pkg::data_t e;
		bit c;
		@(negedge clk);
		if (i_credit !== i_valid || d_credit !== d_valid) begin
			$display("error: i_credit %h d_credit %h, expected %h %h", i_credit, d_credit,
				i_valid, d_valid);
			errors++;
		end
		if (i_valid && exp_i.size() == 0) begin
			$display("instruction port answered a request that was never made");
			errors++;
		end else if (i_valid) begin
			e = exp_i.pop_front();
			if (i_rdata !== e) begin
				$display("error: i_rdata %h, expected %h", i_rdata, e);
				errors++;
			end
		end
		if (d_valid && exp_d.size() == 0) begin
			$display("data port answered a request that was never made");
			errors++;
		end else if (d_valid) begin
			e = exp_d.pop_front();
			c = chk_d.pop_front();
			last_d = d_rdata;
			if (c && d_rdata !== e) begin
				$display("error: d_rdata %h, expected %h", d_rdata, e);
				errors++;
			end
		end
		i_cred += int'(i_credit);
		i_back += int'(i_credit);
		d_cred += int'(d_credit);
		d_back += int'(d_credit);
		i_req = 1'b0;
		d_req = 1'b0;
		d_we = 1'b0;
	endtask

	task automatic put_i(input fsb_pkg::addr_t a, input fsb_pkg::data_t e);
		i_req = 1'b1;
		i_addr = a;
		i_cred--; // One credit per request.
		i_sent++;
		exp_i.push_back(e);
	endtask

	task automatic put_d(input logic we, input fsb_pkg::addr_t a, input fsb_pkg::data_t wd,
			input fsb_pkg::data_t e, input bit c);
		d_req = 1'b1;
		d_we = we;
		d_addr = a;
		d_wdata = wd;
		d_cred--;
		d_sent++;
		exp_d.push_back(e);
		chk_d.push_back(c);
	endtask

	// Data access once the port holds a credit.
	task automatic send_d(input logic we, input fsb_pkg::addr_t a, input fsb_pkg::data_t wd,
			input fsb_pkg::data_t e, input bit c);
		int n;
		n = 0;
		next_cycle();
		while (d_cred == 0) begin
			if (n == TIMEOUT)
				abort_run("timed out waiting for a credit on the data port");
			next_cycle();
			n++;
		end
		put_d(we, a, wd, e, c);
	endtask

	task automatic drain_bus();
		int n;
		n = 0;
		while (exp_i.size() != 0 || exp_d.size() != 0) begin
			if (n == TIMEOUT)
				abort_run("timed out waiting for outstanding responses");
			next_cycle();
			n++;
		end
		if (i_back != i_sent || d_back != d_sent) begin
			$display("credits returned %0d/%0d differ from requests %0d/%0d",
				i_back, d_back, i_sent, d_sent);
			errors++;
		end
	endtask

	task automatic read_data(input fsb_pkg::addr_t a, output fsb_pkg::data_t v);
		send_d(1'b0, a, '0, '0, 1'b0); // Value checked by the caller.
		drain_bus();
		v = last_d;
	endtask

	task automatic end_test(input string name);
		tests++;
		if (errors == test_errs) begin
			$display("test %0d %s: ok", tests, name);
		end else begin
			$display("test %0d %s: %0d errors", tests, name, errors - test_errs);
			tests_failed++;
		end
		test_errs = errors;
	endtask

	initial begin
		fsb_pkg::data_t        v;
		fsb_pkg::data_t        w;
		fsb_pkg::data_t        cmp_v;
		logic [`RAM_AW-1:0]    idx;
		logic [25:0]           off;
		logic [3:0]            dev;
		dev_pkg::switches_t    sw;
		int                    n;
		int unsigned           seed;
		seed = $urandom(85683); // Seed once.
		rst_n = 1'b0;
		i_req = 1'b0;
		i_addr = '0;
		d_req = 1'b0;
		d_we = 1'b0;
		d_addr = '0;
		d_wdata = '0;
		switches = '0;
		i_cred = `FSB_CREDITS;
		d_cred = `FSB_CREDITS;
		{i_sent, d_sent, i_back, d_back} = '0;
		{errors, test_errs, tests, tests_failed} = '0;
		leds_model = '0;
		repeat (10) @(negedge clk);
		rst_n = 1'b1;

		// 1. Idle outputs after reset.
		for (n = 0; n < 5; n++) begin
			next_cycle();
			if (i_valid || d_valid || leds !== '0) begin
				$display("error: i_valid %h d_valid %h leds %h, expected 0", i_valid, d_valid, leds);
				errors++;
			end
		end
		send_d(1'b0, make_addr(4'(`DEV_GPIO), 26'(dev_pkg::GPIO_LED)), '0, '0, 1'b1);
		drain_bus();
		end_test("reset state");

		// 2. Fill the RAM, then random data port traffic.
		for (n = 0; n < `RAM_WORDS; n++) begin
			v = $urandom;
			send_d(1'b1, make_addr(4'(`DEV_RAM), 26'(n)), v, '0, 1'b1);
			ram_model[n] = v;
		end
		for (n = 0; n < 300; n++) begin
			off = 26'($urandom); // High bits fold away.
			idx = off[`RAM_AW-1:0];
			v = $urandom;
			if (v[0]) begin
				send_d(1'b1, make_addr(4'(`DEV_RAM), off), v, '0, 1'b1);
				ram_model[idx] = v;
			end else
				send_d(1'b0, make_addr(4'(`DEV_RAM), off), '0, ram_model[idx], 1'b1);
		end
		drain_bus();
		end_test("ram random");

		// 3. Fetches in the lower half, data traffic in the upper half.
		for (n = 0; n < 200; n++) begin
			next_cycle();
			idx = `RAM_AW'($urandom % (`RAM_WORDS / 2));
			if ($urandom % 3 != 0 && i_cred > 0)
				put_i(make_addr(4'(`DEV_RAM), 26'(idx)), ram_model[idx]);
			idx = `RAM_AW'(`RAM_WORDS / 2 + $urandom % (`RAM_WORDS / 2));
			v = $urandom;
			if (v[1] && d_cred > 0) begin
				if (v[0]) begin
					put_d(1'b1, make_addr(4'(`DEV_RAM), 26'(idx)), v, '0, 1'b1);
					ram_model[idx] = v;
				end else
					put_d(1'b0, make_addr(4'(`DEV_RAM), 26'(idx)), '0, ram_model[idx], 1'b1);
			end
		end
		drain_bus();
		end_test("fetch and data mix");

		// 4. LEDs, then switches through the synchronizer.
		for (n = 0; n < 8; n++) begin
			v = $urandom;
			send_d(1'b1, make_addr(4'(`DEV_GPIO), 26'(dev_pkg::GPIO_LED)), v, '0, 1'b1);
			drain_bus();
			leds_model = dev_pkg::leds_t'(v);
			if (leds !== leds_model) begin
				$display("error: leds %h, expected %h", leds, leds_model);
				errors++;
			end
			send_d(1'b0, make_addr(4'(`DEV_GPIO), 26'(dev_pkg::GPIO_LED)), '0,
				fsb_pkg::data_t'(leds_model), 1'b1);
		end
		drain_bus();
		sw = dev_pkg::switches_t'($urandom | 1);
		switches = sw;
		n = 0;
		read_data(make_addr(4'(`DEV_GPIO), 26'(dev_pkg::GPIO_SW)), v);
		while (v !== fsb_pkg::data_t'(sw)) begin
			if (n == 10)
				abort_run("switch value never reached the GPIO read port");
			read_data(make_addr(4'(`DEV_GPIO), 26'(dev_pkg::GPIO_SW)), v);
			n++;
		end
		end_test("gpio");

		// 5. Timer compare, count order, sticky match.
		cmp_v = 32'h0010_0000 | ($urandom % 32'h1_0000);
		send_d(1'b1, make_addr(4'(`DEV_TIMER), 26'(dev_pkg::TMR_CMP)), cmp_v, '0, 1'b1);
		send_d(1'b0, make_addr(4'(`DEV_TIMER), 26'(dev_pkg::TMR_CMP)), '0, cmp_v, 1'b1);
		drain_bus();
		read_data(make_addr(4'(`DEV_TIMER), 26'(dev_pkg::TMR_COUNT)), w);
		read_data(make_addr(4'(`DEV_TIMER), 26'(dev_pkg::TMR_COUNT)), v);
		if (v < w) begin
			$display("error: count %h read after %h", v, w);
			errors++;
		end
		send_d(1'b1, make_addr(4'(`DEV_TIMER), 26'(dev_pkg::TMR_COUNT)), cmp_v - 2, '0, 1'b1);
		n = 0;
		read_data(make_addr(4'(`DEV_TIMER), 26'(dev_pkg::TMR_MATCH)), v);
		while (v !== 32'd1) begin
			if (n == 20)
				abort_run("timer match flag never set");
			read_data(make_addr(4'(`DEV_TIMER), 26'(dev_pkg::TMR_MATCH)), v);
			n++;
		end
		send_d(1'b1, make_addr(4'(`DEV_TIMER), 26'(dev_pkg::TMR_MATCH)), '0, '0, 1'b1);
		send_d(1'b0, make_addr(4'(`DEV_TIMER), 26'(dev_pkg::TMR_MATCH)), '0, '0, 1'b1);
		drain_bus();
		end_test("timer");

		// 6. Unmapped space reads zero and swallows writes.
		for (n = 0; n < 10; n++) begin
			dev = 4'(3 + $urandom % 13);
			off = 26'($urandom);
			idx = off[`RAM_AW-1:0];
			send_d(1'b0, make_addr(dev, off), '0, '0, 1'b1);
			send_d(1'b1, make_addr(dev, off), $urandom, '0, 1'b1);
			send_d(1'b0, make_addr(4'(`DEV_RAM), off), '0, ram_model[idx], 1'b1); // Same index.
		end
		drain_bus();
		if (leds !== leds_model) begin
			$display("error: leds %h, expected %h", leds, leds_model);
			errors++;
		end
		end_test("unmapped");

		$display("%0d tests run, %0d failed, %0d errors", tests, tests_failed, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

/* test/fsb_checker.sv */
////////////////////////////////////////
// Bus protocol assertions
////////////////////////////////////////
`timescale 1ns/10ps
`include "fsb_macros.svh"

module fsb_checker (
	input logic                                 clk,
	input logic                                 rst_n,
	input logic                                 i_req,
	input logic                                 d_req,
	input logic                                 i_valid,
	input logic                                 d_valid,
	input logic                                 i_credit,
	input logic                                 d_credit,
	input dev_pkg::leds_t                       leds,
	input logic [$clog2(`FSB_QDEPTH + 1)-1:0]   i_q_cnt, // Arbiter fill counts.
	input logic [$clog2(`FSB_QDEPTH + 1)-1:0]   d_q_cnt
);
	localparam logic [2:0] CRED = 3'(`FSB_CREDITS);
	localparam logic [$clog2(`FSB_QDEPTH + 1)-1:0] QFULL = `FSB_QDEPTH;

	logic [2:0] i_cnt; // Credits held by each requester.
	logic [2:0] d_cnt;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			i_cnt <= CRED;
			d_cnt <= CRED;
		end else begin
			i_cnt <= i_cnt - 3'(i_req) + 3'(i_credit); // Spend on req and refill on credit.
			d_cnt <= d_cnt - 3'(d_req) + 3'(d_credit);
		end
	end

	a_credit_max: assert property (@(posedge clk) disable iff (!rst_n)
		(i_cnt <= CRED) && (d_cnt <= CRED))
		else $error("credit count above its limit");

	// A valid and its credit answer an outstanding request.
	a_credit_pair: assert property (@(posedge clk) disable iff (!rst_n)
		(i_valid == i_credit) && (d_valid == d_credit) &&
		(!i_valid || i_cnt < CRED) && (!d_valid || d_cnt < CRED))
		else $error("credit pulse apart from its valid or with no request outstanding");

	// Sampled one edge into reset.
	a_reset_idle: assert property (@(posedge clk)
		!rst_n |=> !(i_valid || d_valid || i_credit || d_credit) && (leds == '0))
		else $error("outputs active during reset");

	a_queue_room: assert property (@(posedge clk) disable iff (!rst_n)
		(i_q_cnt != QFULL || !i_req) && (d_q_cnt != QFULL || !d_req))
		else $error("request accepted into a full queue");

endmodule

bind fsb fsb_checker u_chk (
	.clk      (clk),
	.rst_n    (rst_n),
	.i_req    (i_req),
	.d_req    (d_req),
	.i_valid  (i_valid),
	.d_valid  (d_valid),
	.i_credit (i_credit),
	.d_credit (d_credit),
	.leds     (leds),
	.i_q_cnt  (u_arb.q_cnt[0]),
	.d_q_cnt  (u_arb.q_cnt[1])
);

/* source/fsb.sv */
////////////////////////////////////////
// Front side bus top
////////////////////////////////////////
`timescale 1ns/10ps

module fsb (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               i_req,    // Instruction fetch.
	input  fsb_pkg::addr_t     i_addr,
	output logic               i_valid,
	output fsb_pkg::data_t     i_rdata,
	output logic               i_credit,
	input  logic               d_req,    // Data access.
	input  logic               d_we,
	input  fsb_pkg::addr_t     d_addr,
	input  fsb_pkg::data_t     d_wdata,
	output logic               d_valid,
	output fsb_pkg::data_t     d_rdata,
	output logic               d_credit,
	output dev_pkg::leds_t     leds,     // Board I/O.
	input  dev_pkg::switches_t switches
);
	logic           issue; // Issued request, arbiter to map.
	logic           we;
	fsb_pkg::addr_t addr;
	fsb_pkg::data_t wdata;
	fsb_pkg::data_t rdata; // Merged read word back.

	fsb_dev_if ram_if ();   // One slot per device.
	fsb_dev_if gpio_if ();
	fsb_dev_if timer_if ();

	bus_arbiter u_arb (
		.clk      (clk),
		.rst_n    (rst_n),
		.i_req    (i_req),
		.i_addr   (i_addr),
		.d_req    (d_req),
		.d_we     (d_we),
		.d_addr   (d_addr),
		.d_wdata  (d_wdata),
		.rdata    (rdata),
		.issue    (issue),
		.we       (we),
		.addr     (addr),
		.wdata    (wdata),
		.i_valid  (i_valid),
		.i_rdata  (i_rdata),
		.i_credit (i_credit),
		.d_valid  (d_valid),
		.d_rdata  (d_rdata),
		.d_credit (d_credit)
	);

	mem_map u_map (
		.clk       (clk),
		.rst_n     (rst_n),
		.issue     (issue),
		.we        (we),
		.addr      (addr),
		.wdata     (wdata),
		.rdata     (rdata),
		.ram_bus   (ram_if.host),
		.gpio_bus  (gpio_if.host),
		.timer_bus (timer_if.host)
	);

	mod_ram u_ram (
		.clk (clk),
		.bus (ram_if.dev)
	);

	mod_gpio u_gpio (
		.clk      (clk),
		.rst_n    (rst_n),
		.bus      (gpio_if.dev),
		.leds     (leds),
		.switches (switches)
	);

	mod_timer u_timer (
		.clk   (clk),
		.rst_n (rst_n),
		.bus   (timer_if.dev)
	);

endmodule

/* source/mod_timer.sv */
////////////////////////////////////////
// Timer with compare
////////////////////////////////////////
`timescale 1ns/10ps

module mod_timer (
	input logic    clk,
	input logic    rst_n,
	fsb_dev_if.dev bus
);
	dev_pkg::count_t   count; // Free-running.
	dev_pkg::count_t   cmp;   // Compare value.
	logic              match; // Sticky flag.
	logic              wr;
	dev_pkg::reg_off_t reg_off;

	assign wr = bus.sel && bus.we;
	assign reg_off = bus.off[$bits(dev_pkg::reg_off_t)-1:0];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			count <= '0;
			cmp <= '1; // Far from the reset count.
			match <= 1'b0;
		end else begin
			if (wr && reg_off == dev_pkg::TMR_COUNT)
				count <= bus.wdata; // Load.
			else
				count <= count + 1'b1;
			if (wr && reg_off == dev_pkg::TMR_CMP)
				cmp <= bus.wdata;
			if (wr && reg_off == dev_pkg::TMR_MATCH)
				match <= 1'b0; // Clear wins over a new hit.
			else if (count == cmp)
				match <= 1'b1;
		end
	end

	// Registered read.
	always_ff @(posedge clk) begin
		if (bus.sel) begin
			case (reg_off)
				dev_pkg::TMR_COUNT: bus.rdata <= count;
				dev_pkg::TMR_CMP:   bus.rdata <= cmp;
				dev_pkg::TMR_MATCH: bus.rdata <= fsb_pkg::data_t'(match);
				default:            bus.rdata <= '0;
			endcase
		end
	end

endmodule

/* source/mod_gpio.sv */
////////////////////////////////////////
// LEDs and switches
////////////////////////////////////////
`timescale 1ns/10ps

module mod_gpio (
	input  logic               clk,
	input  logic               rst_n,
	fsb_dev_if.dev             bus,
	output dev_pkg::leds_t     leds,
	input  dev_pkg::switches_t switches
);
	dev_pkg::switches_t sw_meta; // First sync stage.
	dev_pkg::switches_t sw_sync; // Safe to read.
	dev_pkg::reg_off_t  reg_off;

	assign reg_off = bus.off[$bits(dev_pkg::reg_off_t)-1:0];

	// Switches are asynchronous to clk.
	always_ff @(posedge clk) begin
		sw_meta <= switches;
		sw_sync <= sw_meta;
	end

	// LED register, dark after reset.
	always_ff @(posedge clk) begin
		if (!rst_n)
			leds <= '0;
		else if (bus.sel && bus.we && reg_off == dev_pkg::GPIO_LED)
			leds <= bus.wdata[$bits(dev_pkg::leds_t)-1:0];
	end

	// Read mux, zero-extended.
	always_ff @(posedge clk) begin
		if (bus.sel) begin
			case (reg_off)
				dev_pkg::GPIO_LED: bus.rdata <= fsb_pkg::data_t'(leds);
				dev_pkg::GPIO_SW:  bus.rdata <= fsb_pkg::data_t'(sw_sync);
				default:           bus.rdata <= '0; // Offsets 2 and 3.
			endcase
		end
	end

endmodule

/* source/mod_ram.sv */
////////////////////////////////////////
// Word RAM
////////////////////////////////////////
`timescale 1ns/10ps
`include "fsb_macros.svh"

module mod_ram (
	input logic    clk,
	fsb_dev_if.dev bus
);
	fsb_pkg::data_t   mem [`RAM_WORDS]; // Word array.
	logic [`RAM_AW-1:0] idx;            // Folded word index.

	// Upper offset bits are dropped, so addresses wrap.
	assign idx = bus.off[`RAM_AW-1:0];

	// Write and registered read on the issue edge.
	always_ff @(posedge clk) begin
		if (bus.sel) begin
			if (bus.we)
				mem[idx] <= bus.wdata;
			bus.rdata <= mem[idx]; // Old word, unused on writes.
		end
	end

endmodule

/* source/mem_map.sv */
////////////////////////////////////////
// Address decoder
////////////////////////////////////////
`timescale 1ns/10ps
`include "fsb_macros.svh"

module mem_map (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           issue,
	input  logic           we,
	input  fsb_pkg::addr_t addr,
	input  fsb_pkg::data_t wdata,
	output fsb_pkg::data_t rdata,
	fsb_dev_if.host        ram_bus,
	fsb_dev_if.host        gpio_bus,
	fsb_dev_if.host        timer_bus
);
	localparam int DW = $bits(fsb_pkg::data_t);

	fsb_pkg::dev_id_t   dev_id; // Top nibble.
	fsb_pkg::eff_addr_t eff;    // Word offset.
	logic [2:0]         hit;    // {timer, gpio, ram}.
	logic [2:0]         rd_sel; // Slot answering a read now.

	assign dev_id = addr[$bits(fsb_pkg::addr_t)-1 -: $bits(fsb_pkg::dev_id_t)];
	assign eff = addr[2 +: $bits(fsb_pkg::eff_addr_t)]; // Byte to word.

	// Unmapped codes select nothing.
	assign hit[0] = issue && (dev_id == fsb_pkg::dev_id_t'(`DEV_RAM));
	assign hit[1] = issue && (dev_id == fsb_pkg::dev_id_t'(`DEV_GPIO));
	assign hit[2] = issue && (dev_id == fsb_pkg::dev_id_t'(`DEV_TIMER));

	assign ram_bus.sel = hit[0];
	assign ram_bus.we = we;
	assign ram_bus.off = eff;
	assign ram_bus.wdata = wdata;
	assign gpio_bus.sel = hit[1];
	assign gpio_bus.we = we;
	assign gpio_bus.off = eff;
	assign gpio_bus.wdata = wdata;
	assign timer_bus.sel = hit[2];
	assign timer_bus.we = we;
	assign timer_bus.off = eff;
	assign timer_bus.wdata = wdata;

	// Writes answer with zero, so only reads are remembered.
	always_ff @(posedge clk) begin
		if (!rst_n)
			rd_sel <= '0;
		else
			rd_sel <= we ? 3'b000 : hit;
	end

	// OR-merge of the selected slot.
	assign rdata = ({DW{rd_sel[0]}} & ram_bus.rdata) |
		({DW{rd_sel[1]}} & gpio_bus.rdata) |
		({DW{rd_sel[2]}} & timer_bus.rdata);

endmodule

/* source/bus_arbiter.sv */
////////////////////////////////////////
// Round-robin port arbiter
////////////////////////////////////////
`timescale 1ns/10ps
`include "fsb_macros.svh"

module bus_arbiter (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           i_req,
	input  fsb_pkg::addr_t i_addr,
	input  logic           d_req,
	input  logic           d_we,
	input  fsb_pkg::addr_t d_addr,
	input  fsb_pkg::data_t d_wdata,
	input  fsb_pkg::data_t rdata,
	output logic           issue,
	output logic           we,
	output fsb_pkg::addr_t addr,
	output fsb_pkg::data_t wdata,
	output logic           i_valid,
	output fsb_pkg::data_t i_rdata,
	output logic           i_credit,
	output logic           d_valid,
	output fsb_pkg::data_t d_rdata,
	output logic           d_credit
);
	localparam int PW = $clog2(`FSB_QDEPTH);     // Pointer width.
	localparam int CW = $clog2(`FSB_QDEPTH + 1); // Fill count width.

	logic           in_req   [2]; // Requests by port tag.
	logic           in_we    [2];
	fsb_pkg::addr_t in_addr  [2];
	fsb_pkg::data_t in_wdata [2];

	logic           q_we    [2][`FSB_QDEPTH]; // Queue payload.
	fsb_pkg::addr_t q_addr  [2][`FSB_QDEPTH];
	fsb_pkg::data_t q_wdata [2][`FSB_QDEPTH];

	logic [PW-1:0]  rd_ptr [2];
	logic [PW-1:0]  wr_ptr [2];
	logic [CW-1:0]  q_cnt  [2];
	logic [1:0]     q_busy; // Queue holds an entry.
	logic [1:0]     q_pop;  // Head leaves this cycle.

	fsb_pkg::port_t rr_next; // Favored port when both wait.
	fsb_pkg::port_t tag;     // Port issued this cycle.
	logic           rsp_vld; // Response due this cycle.
	fsb_pkg::port_t rsp_tag; // Its owner.

	// Instruction port is read only.
	always_comb begin
		in_req[fsb_pkg::PORT_I] = i_req;
		in_we[fsb_pkg::PORT_I] = 1'b0;
		in_addr[fsb_pkg::PORT_I] = i_addr;
		in_wdata[fsb_pkg::PORT_I] = '0;
		in_req[fsb_pkg::PORT_D] = d_req;
		in_we[fsb_pkg::PORT_D] = d_we;
		in_addr[fsb_pkg::PORT_D] = d_addr;
		in_wdata[fsb_pkg::PORT_D] = d_wdata;
	end

	// Pick a port and alternate only when both queues wait.
	always_comb begin
		for (int p = 0; p < 2; p++)
			q_busy[p] = (q_cnt[p] != '0);
		if (q_busy[0] && q_busy[1])
			tag = rr_next;
		else if (q_busy[fsb_pkg::PORT_D])
			tag = fsb_pkg::PORT_D;
		else
			tag = fsb_pkg::PORT_I;
		for (int p = 0; p < 2; p++)
			q_pop[p] = q_busy[p] && (tag == fsb_pkg::port_t'(p));
	end

	assign issue = |q_busy;                      // Never from an empty queue.
	assign we = q_we[tag][rd_ptr[tag]];          // Oldest entry.
	assign addr = q_addr[tag][rd_ptr[tag]];
	assign wdata = q_wdata[tag][rd_ptr[tag]];

	// Payload capture on the req edge.
	always_ff @(posedge clk) begin
		for (int p = 0; p < 2; p++) begin
			if (in_req[p]) begin
				q_we[p][wr_ptr[p]] <= in_we[p];
				q_addr[p][wr_ptr[p]] <= in_addr[p];
				q_wdata[p][wr_ptr[p]] <= in_wdata[p];
			end
		end
		rsp_tag <= tag;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int p = 0; p < 2; p++) begin
				rd_ptr[p] <= '0;
				wr_ptr[p] <= '0;
				q_cnt[p] <= '0;
			end
			rr_next <= fsb_pkg::PORT_I;
			rsp_vld <= 1'b0;
		end else begin
			for (int p = 0; p < 2; p++) begin
				if (in_req[p]) // Credits keep this from overflowing.
					wr_ptr[p] <= (wr_ptr[p] == PW'(`FSB_QDEPTH - 1)) ? '0 : wr_ptr[p] + 1'b1;
				if (q_pop[p])
					rd_ptr[p] <= (rd_ptr[p] == PW'(`FSB_QDEPTH - 1)) ? '0 : rd_ptr[p] + 1'b1;
				case ({in_req[p], q_pop[p]})
					2'b10:   q_cnt[p] <= q_cnt[p] + 1'b1;
					2'b01:   q_cnt[p] <= q_cnt[p] - 1'b1;
					default: q_cnt[p] <= q_cnt[p]; // Push and pop cancel.
				endcase
			end
			if (issue)
				rr_next <= ~tag; // Other port next time.
			rsp_vld <= issue;
		end
	end

	// Response steering one cycle after issue.
	assign i_valid = rsp_vld && (rsp_tag == fsb_pkg::PORT_I);
	assign d_valid = rsp_vld && (rsp_tag == fsb_pkg::PORT_D);
	assign i_credit = i_valid; // Credit rides with valid.
	assign d_credit = d_valid;
	assign i_rdata = i_valid ? rdata : '0;
	assign d_rdata = d_valid ? rdata : '0; // The map zeroes rdata for writes.

endmodule

/* source/fsb_dev_if.sv */
////////////////////////////////////////
// Device slot interface
////////////////////////////////////////
`timescale 1ns/10ps

interface fsb_dev_if;

	logic                 sel;   // Slot picked this cycle.
	logic                 we;    // Write when high.
	fsb_pkg::eff_addr_t   off;   // Word offset in device.
	fsb_pkg::data_t       wdata; // Write data.
	fsb_pkg::data_t       rdata; // Registered read word.

	// Map side drives the request.
	modport host (
		output sel,
		output we,
		output off,
		output wdata,
		input  rdata
	);

	// Device side answers with rdata one edge later.
	modport dev (
		input  sel,
		input  we,
		input  off,
		input  wdata,
		output rdata
	);

endinterface

/* source/dev_pkg.sv */
////////////////////////////////////////
// Peripheral types
////////////////////////////////////////
package dev_pkg;

	// Register index inside one peripheral.
	typedef logic [1:0] reg_off_t;

	typedef logic [7:0] leds_t;     // LED register.
	typedef logic [3:0] switches_t; // Board switches.
	typedef logic [31:0] count_t;   // Timer count and compare.

	// GPIO register map.
	localparam reg_off_t GPIO_LED = 2'd0;
	localparam reg_off_t GPIO_SW = 2'd1;

	// Timer register map.
	localparam reg_off_t TMR_COUNT = 2'd0;
	localparam reg_off_t TMR_CMP = 2'd1;
	localparam reg_off_t TMR_MATCH = 2'd2; // Sticky, write clears.

endpackage

/* source/fsb_pkg.sv */
////////////////////////////////////////
// Bus level types
////////////////////////////////////////
package fsb_pkg;

	// CPU byte address, top nibble picks the device.
	typedef logic [31:0] addr_t;

	// One bus data word.
	typedef logic [31:0] data_t;

	// Map field, taken from addr[31:28].
	typedef logic [3:0] dev_id_t;

	// Word offset inside a device, addr[27:2].
	typedef logic [25:0] eff_addr_t;

	// Tag that routes a response back to its CPU port.
	typedef logic port_t;

	localparam port_t PORT_I = 1'b0; // Instruction port.
	localparam port_t PORT_D = 1'b1; // Data port.

endpackage

/* include/fsb_macros.svh */
////////////////////////////////////////
// Front side bus parameters
////////////////////////////////////////
`ifndef FSB_MACROS_SVH
`define FSB_MACROS_SVH

// Credits per CPU port after reset.
`define FSB_CREDITS 2

// Queue depth per port, equal to the credit count so a queue never overflows.
`define FSB_QDEPTH `FSB_CREDITS

// RAM word-address width, and the resulting word count.
`define RAM_AW 8
`define RAM_WORDS (1 << `RAM_AW)

// Memory map codes, from the top address nibble.
`define DEV_RAM 0
`define DEV_GPIO 1
`define DEV_TIMER 2 // Anything else is unmapped.

`endif
